// File: ifm_bank_ring.f
logic/ifm_geom_pkg.sv
logic/ifm_port_pkg.sv
logic/ifm_bank.sv
logic/ifm_port_router.sv
logic/ifm_read_mux.sv
logic/ifm_bank_ring.sv
tb/tb_clock_gen.sv
tb/tb_ifm_checker.sv
tb/tb_ifm_bank_ring.sv

// File: logic/ifm_bank.sv
module ifm_bank (
	input  logic                     clk,
	input  logic                     rst_n,
	input  ifm_port_pkg::bank_req_t  req,
	output ifm_port_pkg::lane_data_t a_data,
	output ifm_port_pkg::lane_data_t b_data
);

	import ifm_geom_pkg::*;
	import ifm_port_pkg::*;

	data_t mem [NUM_LANES][IFM_DEPTH];

	lane_data_t a_word;
	lane_data_t b_word;
	logic a_wr;
	logic a_rd;

	assign a_wr = req.a_en && req.a_we;
	assign a_rd = req.a_en && !req.a_we;

	// A write on port A fills the same address in every lane
	always_ff @(posedge clk)
	begin
		if (a_wr)
		begin
			for (int l = 0; l < NUM_LANES; l++)
				mem[l][req.a_addr] <= req.wr_data[l];
		end
	end

	always_comb
	begin
		for (int l = 0; l < NUM_LANES; l++)
		begin
			a_word[l] = mem[l][req.a_addr];
			b_word[l] = mem[l][req.b_addr];
		end
	end

	// Output registers keep the last word read while their port is idle
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			a_data <= '0;
			b_data <= '0;
		end
		else
		begin
			if (a_rd)
				a_data <= a_word;
			if (req.b_en)
				b_data <= b_word;
		end
	end

	// Addresses come from the layers outside the ring and are not checked in logic
	a_addr_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		req.a_en |-> (int'(req.a_addr) < IFM_DEPTH)
	);

	b_addr_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		req.b_en |-> (int'(req.b_addr) < IFM_DEPTH)
	);

endmodule

// File: logic/ifm_bank_ring.sv
module ifm_bank_ring #(
	parameter int N_BANKS = 8
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  ifm_geom_pkg::bank_sel_t   sel,
	input  ifm_port_pkg::prod_req_t   prod_req,
	input  ifm_port_pkg::cons_req_t   cons_req,
	output ifm_port_pkg::lane_data_t  prod_rd_data,
	output ifm_port_pkg::cons_data_t  cons_data
);

	import ifm_geom_pkg::*;
	import ifm_port_pkg::*;

	bank_req_t  bank_req [N_BANKS];
	lane_data_t bank_a_data [N_BANKS];
	lane_data_t bank_b_data [N_BANKS];

	if (N_BANKS < 2 || N_BANKS > MAX_BANKS)
	begin : g_bad_count
		$error("ifm_bank_ring: N_BANKS %0d outside 2 to %0d", N_BANKS, MAX_BANKS);
	end

	ifm_port_router #(
		.N_BANKS (N_BANKS)
	) u_router (
		.sel      (sel),
		.prod_req (prod_req),
		.cons_req (cons_req),
		.bank_req (bank_req)
	);

	for (genvar b = 0; b < N_BANKS; b++)
	begin : g_bank
		ifm_bank u_bank (
			.clk    (clk),
			.rst_n  (rst_n),
			.req    (bank_req[b]),
			.a_data (bank_a_data[b]),
			.b_data (bank_b_data[b])
		);
	end

	ifm_read_mux #(
		.N_BANKS (N_BANKS)
	) u_read_mux (
		.clk          (clk),
		.rst_n        (rst_n),
		.sel          (sel),
		.bank_a_data  (bank_a_data),
		.bank_b_data  (bank_b_data),
		.prod_rd_data (prod_rd_data),
		.cons_data    (cons_data)
	);

endmodule

// File: logic/ifm_geom_pkg.sv
package ifm_geom_pkg;

	// Feature map is IFM_SIZE by IFM_SIZE words, stored row after row in one lane
	parameter int IFM_SIZE = 5;
	parameter int IFM_DEPTH = IFM_SIZE * IFM_SIZE;

	// Each bank carries this many lanes side by side
	parameter int NUM_LANES = 2;
	parameter int MAX_BANKS = 8;

	parameter int DATA_W = 32;
	parameter int ADDR_W = $clog2(IFM_DEPTH);
	parameter int SEL_W = $clog2(MAX_BANKS);

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [SEL_W-1:0] bank_sel_t;

	// Bank that the consuming layer reads, one behind the select
	// Wraps from bank zero to the last bank in use
	function automatic bank_sel_t prev_bank(input bank_sel_t cur, input int n_banks);
		bank_sel_t prev;
		if (cur == '0)
			prev = bank_sel_t'(n_banks - 1);
		else
			prev = cur - 1'b1;
		return prev;
	endfunction

endpackage

// File: logic/ifm_port_pkg.sv
package ifm_port_pkg;

	// One word per lane, lane 0 in the low bits
	typedef ifm_geom_pkg::data_t [ifm_geom_pkg::NUM_LANES-1:0] lane_data_t;

	// Producing layer writes the current bank and reads it back on port B
	typedef struct packed {
		logic                 wr_en;
		ifm_geom_pkg::addr_t  wr_addr;
		lane_data_t           wr_data;
		logic                 rd_en;
		ifm_geom_pkg::addr_t  rd_addr;
	} prod_req_t;

	// Consuming layer reads the previous bank on both ports
	typedef struct packed {
		logic                 a_en;
		ifm_geom_pkg::addr_t  a_addr;
		logic                 b_en;
		ifm_geom_pkg::addr_t  b_addr;
	} cons_req_t;

	typedef struct packed {
		lane_data_t a;
		lane_data_t b;
	} cons_data_t;

	// Request seen by a single bank after routing
	// Port A either writes or reads in a cycle, port B only reads
	typedef struct packed {
		logic                 a_en;
		logic                 a_we;
		ifm_geom_pkg::addr_t  a_addr;
		lane_data_t           wr_data;
		logic                 b_en;
		ifm_geom_pkg::addr_t  b_addr;
	} bank_req_t;

endpackage

// File: logic/ifm_port_router.sv
module ifm_port_router #(
	parameter int N_BANKS = 8
) (
	input  ifm_geom_pkg::bank_sel_t sel,
	input  ifm_port_pkg::prod_req_t prod_req,
	input  ifm_port_pkg::cons_req_t cons_req,
	output ifm_port_pkg::bank_req_t bank_req [N_BANKS]
);

	import ifm_geom_pkg::*;
	import ifm_port_pkg::*;

	bank_sel_t prev_sel;
	bank_req_t prod_side;
	bank_req_t cons_side;

	assign prev_sel = prev_bank(sel, N_BANKS);

	// Producer writes through port A and reads back through port B
	always_comb
	begin
		prod_side = '0;
		prod_side.a_en = prod_req.wr_en;
		prod_side.a_we = prod_req.wr_en;
		prod_side.a_addr = prod_req.wr_addr;
		prod_side.wr_data = prod_req.wr_data;
		prod_side.b_en = prod_req.rd_en;
		prod_side.b_addr = prod_req.rd_addr;
	end

	// Consumer only reads, so the write flag and data stay low
	always_comb
	begin
		cons_side = '0;
		cons_side.a_en = cons_req.a_en;
		cons_side.a_addr = cons_req.a_addr;
		cons_side.b_en = cons_req.b_en;
		cons_side.b_addr = cons_req.b_addr;
	end

	// With at least two banks the current and previous bank never coincide,
	// so every bank has exactly one role
	always_comb
	begin
		for (int b = 0; b < N_BANKS; b++)
		begin
			if (bank_sel_t'(b) == sel)
				bank_req[b] = prod_side;
			else if (bank_sel_t'(b) == prev_sel)
				bank_req[b] = cons_side;
			else
				bank_req[b] = '0;
		end
	end

	// A select past the last bank would leave the producer without a bank
	always_comb
	begin
		sel_in_range: assert (int'(sel) < N_BANKS)
			else $error("ifm_port_router: sel %0d with only %0d banks", sel, N_BANKS);
	end

endmodule

// File: logic/ifm_read_mux.sv
module ifm_read_mux #(
	parameter int N_BANKS = 8
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  ifm_geom_pkg::bank_sel_t   sel,
	input  ifm_port_pkg::lane_data_t  bank_a_data [N_BANKS],
	input  ifm_port_pkg::lane_data_t  bank_b_data [N_BANKS],
	output ifm_port_pkg::lane_data_t  prod_rd_data,
	output ifm_port_pkg::cons_data_t  cons_data
);

	import ifm_geom_pkg::*;
	import ifm_port_pkg::*;

	bank_sel_t sel_q;
	bank_sel_t prev_q;

	// Bank data shows up one cycle after the request, so steer with the
	// select of that request cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			sel_q <= '0;
		else
			sel_q <= sel;
	end

	assign prev_q = prev_bank(sel_q, N_BANKS);

	always_comb
	begin
		prod_rd_data = '0;
		cons_data = '0;
		for (int b = 0; b < N_BANKS; b++)
		begin
			if (bank_sel_t'(b) == sel_q)
				prod_rd_data = bank_b_data[b];
			if (bank_sel_t'(b) == prev_q)
			begin
				cons_data.a = bank_a_data[b];
				cons_data.b = bank_b_data[b];
			end
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the ring testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
	-f ifm_bank_ring.f \
	--top-module tb_ifm_bank_ring \
	-Mdir "$BUILD_DIR" -o sim_tb > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Build failed with status $status"
	exit 1
fi

"$BUILD_DIR/sim_tb" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" "$SIM_LOG"; then
	exit 1
fi
exit 0

// File: tb/tb_clock_gen.sv
module tb_clock_gen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset is let go on a falling edge so the first active edge sees it stable
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// File: tb/tb_ifm_bank_ring.sv
module tb_ifm_bank_ring;

	import ifm_geom_pkg::*;
	import ifm_port_pkg::*;

	localparam int N_BANKS = 8;
	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_TESTS = 7;
	localparam int RANDOM_CYCLES = 400;

	// Cycle budget of each test, summed to size the watchdog
	localparam int RESET_WAIT = RESET_CYCLES + 4;
	localparam int FILL_CYCLES = N_BANKS * (IFM_DEPTH + 1);
	localparam int READBACK_CYCLES = 2 * IFM_DEPTH + 1;
	localparam int ROTATION_CYCLES = N_BANKS * 12;
	localparam int WRAP_CYCLES = 2 * N_BANKS + 6;
	localparam int HOLD_CYCLES = 14;
	localparam int GAP_CYCLES = 3 * NUM_TESTS;
	localparam int PLANNED_CYCLES = RESET_WAIT + FILL_CYCLES + READBACK_CYCLES
		+ ROTATION_CYCLES + WRAP_CYCLES + HOLD_CYCLES + RANDOM_CYCLES + GAP_CYCLES;
	localparam int WATCHDOG_CYCLES = PLANNED_CYCLES + 100;

	logic clk;
	logic rst_n;
	bank_sel_t sel;
	prod_req_t prod_req;
	cons_req_t cons_req;
	lane_data_t prod_rd_data;
	cons_data_t cons_data;
	int test_num;
	int error_count;
	logic report_done;
	int seed;

	tb_clock_gen #(
		.PERIOD       (CLK_PERIOD),
		.RESET_CYCLES (RESET_CYCLES)
	) u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	ifm_bank_ring #(
		.N_BANKS (N_BANKS)
	) dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.sel          (sel),
		.prod_req     (prod_req),
		.cons_req     (cons_req),
		.prod_rd_data (prod_rd_data),
		.cons_data    (cons_data)
	);

	tb_ifm_checker #(
		.N_BANKS   (N_BANKS),
		.NUM_TESTS (NUM_TESTS)
	) u_checker (
		.clk          (clk),
		.rst_n        (rst_n),
		.sel          (sel),
		.prod_req     (prod_req),
		.cons_req     (cons_req),
		.prod_rd_data (prod_rd_data),
		.cons_data    (cons_data),
		.test_num     (test_num),
		.error_count  (error_count),
		.report_done  (report_done)
	);

	function automatic int rand_below(input int n);
		int unsigned r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	function automatic addr_t rand_addr();
		return addr_t'(rand_below(IFM_DEPTH));
	endfunction

	function automatic lane_data_t rand_lanes();
		lane_data_t d;
		for (int l = 0; l < NUM_LANES; l++)
			d[l] = data_t'($random(seed));
		return d;
	endfunction

	// Every bank, lane and word gets its own value
	function automatic data_t fill_word(input int bank, input int lane, input int addr);
		return data_t'(32'hA500_0000 ^ (bank << 16) ^ (lane << 8) ^ addr);
	endfunction

	task automatic drive(input prod_req_t p, input cons_req_t c);
		@(negedge clk);
		prod_req = p;
		cons_req = c;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) drive('0, '0);
	endtask

	task automatic set_sel(input int bank);
		@(negedge clk);
		sel = bank_sel_t'(bank);
		prod_req = '0;
		cons_req = '0;
	endtask

	task automatic prod_write(input addr_t addr, input lane_data_t data);
		prod_req_t p;
		p = '0;
		p.wr_en = 1'b1;
		p.wr_addr = addr;
		p.wr_data = data;
		drive(p, '0);
	endtask

	task automatic prod_read(input addr_t addr);
		prod_req_t p;
		p = '0;
		p.rd_en = 1'b1;
		p.rd_addr = addr;
		drive(p, '0);
	endtask

	task automatic cons_read(input addr_t a_addr, input addr_t b_addr);
		cons_req_t c;
		c.a_en = 1'b1;
		c.a_addr = a_addr;
		c.b_en = 1'b1;
		c.b_addr = b_addr;
		drive('0, c);
	endtask

	task automatic next_test();
		idle(3);
		test_num = test_num + 1;
	endtask

	task automatic fill_all_banks();
		lane_data_t d;
		for (int b = 0; b < N_BANKS; b++)
		begin
			set_sel(b);
			for (int a = 0; a < IFM_DEPTH; a++)
			begin
				for (int l = 0; l < NUM_LANES; l++)
					d[l] = fill_word(b, l, a);
				prod_write(addr_t'(a), d);
			end
		end
	endtask

	task automatic producer_readback();
		set_sel(3);
		for (int a = 0; a < IFM_DEPTH; a++)
			prod_write(addr_t'(a), rand_lanes());
		// Back to back reads, the first one right after the last write
		for (int a = IFM_DEPTH - 1; a >= 0; a--)
			prod_read(addr_t'(a));
	endtask

	task automatic consumer_rotation();
		addr_t addrs [5];
		for (int k = 0; k < N_BANKS; k++)
		begin
			set_sel(k);
			for (int i = 0; i < 5; i++)
			begin
				addrs[i] = rand_addr();
				prod_write(addrs[i], rand_lanes());
			end
			set_sel((k + 1) % N_BANKS);
			for (int i = 0; i < 5; i++)
				cons_read(addrs[i], addr_t'((int'(addrs[i]) + 1 + i % 3) % IFM_DEPTH));
		end
	endtask

	task automatic wrap_around();
		lane_data_t mark;
		mark[0] = 32'hC0DE_0001;
		mark[1] = 32'hC0DE_0002;
		set_sel(0);
		prod_write(addr_t'(12), mark);
		for (int s = 1; s < N_BANKS; s++)
		begin
			set_sel(s);
			cons_read(addr_t'(12), addr_t'(12));
		end
		mark[0] = 32'hE1D0_0003;
		mark[1] = 32'hE1D0_0004;
		set_sel(N_BANKS - 1);
		prod_write(addr_t'(4), mark);
		set_sel(0);
		cons_read(addr_t'(4), addr_t'(4));
	endtask

	task automatic output_hold();
		prod_req_t p;
		cons_req_t c;
		set_sel(2);
		p = '0;
		p.rd_en = 1'b1;
		p.rd_addr = addr_t'(7);
		c.a_en = 1'b1;
		c.a_addr = addr_t'(9);
		c.b_en = 1'b1;
		c.b_addr = addr_t'(10);
		drive(p, c);
		idle(6);
		cons_read(addr_t'(3), addr_t'(20));
		idle(5);
	endtask

	// Select moves only in cycles that issue no read
	task automatic random_traffic();
		prod_req_t p;
		cons_req_t c;
		for (int i = 0; i < RANDOM_CYCLES; i++)
		begin
			if (rand_below(8) == 0)
				set_sel(rand_below(N_BANKS));
			else
			begin
				p.wr_en = rand_below(2) == 1;
				p.wr_addr = rand_addr();
				p.wr_data = rand_lanes();
				p.rd_en = rand_below(3) != 0;
				p.rd_addr = rand_addr();
				c.a_en = rand_below(3) != 0;
				c.a_addr = rand_addr();
				c.b_en = rand_below(3) != 0;
				c.b_addr = rand_addr();
				drive(p, c);
			end
		end
	endtask

	initial
	begin
		seed = 32'h7c723446;
		sel = '0;
		prod_req = '0;
		cons_req = '0;
		test_num = 0;
		wait (rst_n === 1'b1);
		idle(4);
		next_test();
		fill_all_banks();
		next_test();
		producer_readback();
		next_test();
		consumer_rotation();
		next_test();
		wrap_around();
		next_test();
		output_hold();
		next_test();
		random_traffic();
		next_test();
		wait (report_done === 1'b1);
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: tb/tb_ifm_checker.sv
module tb_ifm_checker #(
	parameter int N_BANKS = 8,
	parameter int NUM_TESTS = 7
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  ifm_geom_pkg::bank_sel_t   sel,
	input  ifm_port_pkg::prod_req_t   prod_req,
	input  ifm_port_pkg::cons_req_t   cons_req,
	input  ifm_port_pkg::lane_data_t  prod_rd_data,
	input  ifm_port_pkg::cons_data_t  cons_data,
	input  int                        test_num,
	output int                        error_count,
	output logic                      report_done
);

	import ifm_geom_pkg::*;
	import ifm_port_pkg::*;

	data_t model [N_BANKS][NUM_LANES][IFM_DEPTH];

	lane_data_t exp_prod;
	lane_data_t exp_a;
	lane_data_t exp_b;
	logic prod_valid;
	logic a_valid;
	logic b_valid;
	bank_sel_t last_sel;
	int cur_test;
	int test_checks;
	int test_errors;
	int total_checks;

	function automatic string test_name(input int n);
		case (n)
			0: return "reset_zero";
			1: return "fill_all";
			2: return "prod_readback";
			3: return "cons_rotation";
			4: return "wrap";
			5: return "hold";
			6: return "random_traffic";
			default: return "unknown";
		endcase
	endfunction

	task automatic compare_lanes(input string what, input lane_data_t expected,
		input lane_data_t actual);
		test_checks++;
		total_checks++;
		if (actual !== expected)
		begin
			test_errors++;
			error_count++;
			$display("Mismatch in %s, %s: expected %h, actual %h",
				test_name(cur_test), what, expected, actual);
		end
	endtask

	// Outputs are read at the rising edge before the DUT registers move,
	// so each value seen here answers the requests of the previous edge
	always @(posedge clk)
	begin
		int cur;
		int prev;
		cur = int'(sel);
		prev = (cur == 0) ? N_BANKS - 1 : cur - 1;
		if (!rst_n)
		begin
			exp_prod = '0;
			exp_a = '0;
			exp_b = '0;
			prod_valid = 1'b1;
			a_valid = 1'b1;
			b_valid = 1'b1;
			last_sel = '0;
			cur_test = 0;
			test_checks = 0;
			test_errors = 0;
			total_checks = 0;
			error_count = 0;
			report_done = 1'b0;
		end
		else
		begin
			if (prod_valid)
				compare_lanes("producer read", exp_prod, prod_rd_data);
			if (a_valid)
				compare_lanes("consumer port A", exp_a, cons_data.a);
			if (b_valid)
				compare_lanes("consumer port B", exp_b, cons_data.b);
			if (test_num != cur_test && !report_done)
			begin
				$display("Test %0d %s: %0d checks, %0d errors",
					cur_test, test_name(cur_test), test_checks, test_errors);
				test_checks = 0;
				test_errors = 0;
				cur_test = test_num;
				if (test_num >= NUM_TESTS)
				begin
					$display("Total: %0d tests, %0d checks, %0d errors",
						NUM_TESTS, total_checks, error_count);
					report_done = 1'b1;
				end
			end
			// A new select shows other banks' held words until the next read
			if (sel != last_sel)
			begin
				prod_valid = 1'b0;
				a_valid = 1'b0;
				b_valid = 1'b0;
			end
			for (int l = 0; l < NUM_LANES; l++)
			begin
				if (prod_req.rd_en)
					exp_prod[l] = model[cur][l][prod_req.rd_addr];
				if (cons_req.a_en)
					exp_a[l] = model[prev][l][cons_req.a_addr];
				if (cons_req.b_en)
					exp_b[l] = model[prev][l][cons_req.b_addr];
			end
			if (prod_req.rd_en)
				prod_valid = 1'b1;
			if (cons_req.a_en)
				a_valid = 1'b1;
			if (cons_req.b_en)
				b_valid = 1'b1;
			// Reads above see the old word, a write lands after them
			if (prod_req.wr_en)
			begin
				for (int l = 0; l < NUM_LANES; l++)
					model[cur][l][prod_req.wr_addr] = prod_req.wr_data[l];
			end
			last_sel = sel;
		end
	end

endmodule
